//--- hdl/ooo_ctrl_pkg.sv
`default_nettype none

package ooo_ctrl_pkg;

  // architectural register file
  localparam int NUM_REGS  = 32;
  localparam int REG_IDX_W = 5;

  // completion buffer geometry
  localparam int CB_DEPTH = 8;
  localparam int CB_IDX_W = 3;

  // pc and data word width
  localparam int XLEN = 32;

  // functional unit that an instruction is steered to
  typedef enum logic [1:0] {
    ALU_S,
    MUL_S,
    DIV_S,
    LOADSTORE_S
  } fu_type_t;

  // operand source select, the first two read the register file
  typedef enum logic [1:0] {
    SRC_RS,
    SRC_RS_IMM,
    SRC_PC,
    SRC_IMM
  } src_sel_t;

  // trap cause codes as held in the buffer and in mcause
  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_MAL_INSN,
    EXC_ILLEGAL,
    EXC_MAL_L,
    EXC_MAL_S,
    EXC_BREAK,
    EXC_ECALL,
    INTR_EXT
  } exc_cause_t;

  // machine register select on the config port
  typedef enum logic [1:0] {
    CSR_MTVEC,
    CSR_MIE,
    CSR_MEPC,
    CSR_MCAUSE
  } csr_addr_t;

endpackage

`default_nettype wire

//--- hdl/register_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module register_scoreboard
  import ooo_ctrl_pkg::*;
(
  input  logic                 CLK,
  input  logic                 rst,
  // accepted dispatch from decode
  input  logic                 dispatch_ok,
  input  logic                 wen,
  input  logic [REG_IDX_W-1:0] rs1,
  input  logic [REG_IDX_W-1:0] rs2,
  input  logic [REG_IDX_W-1:0] rd,
  // writeback side
  input  logic                 wb_wen,
  input  logic [REG_IDX_W-1:0] wb_rd,
  // lookups for the hazard unit
  output logic                 rs1_busy,
  output logic                 rs2_busy,
  output logic                 rd_busy
);

  // one pending-write bit per architectural register
  logic [NUM_REGS-1:0] busy;
  logic                set_en;
  logic                clr_en;

  // x0 is hardwired, so it never becomes busy
  assign set_en = dispatch_ok && wen && (rd != '0);
  assign clr_en = wb_wen && (wb_rd != '0);

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy <= '0;
    end else begin
      // clear first so that a same-edge set of the same register wins
      if (clr_en) begin
        busy[wb_rd] <= 1'b0;
      end
      if (set_en) begin
        busy[rd] <= 1'b1;
      end
    end
  end

  // combinational lookup of the decoding instruction's operands
  // register 0 reads idle regardless of the vector
  assign rs1_busy = (rs1 != '0) && busy[rs1];
  assign rs2_busy = (rs2 != '0) && busy[rs2];
  assign rd_busy  = (rd != '0) && busy[rd];

endmodule

`default_nettype wire

//--- hdl/completion_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module completion_buffer
  import ooo_ctrl_pkg::*;
(
  input  logic                CLK,
  input  logic                rst,
  // allocation in program order
  input  logic                dispatch_ok,
  input  logic [XLEN-1:0]     pc_de,
  // completion in any order
  input  logic                wb_valid,
  input  logic [CB_IDX_W-1:0] wb_cb_idx,
  input  exc_cause_t          wb_exc,
  // status and retirement
  output logic [CB_IDX_W-1:0] dispatch_cb_idx,
  output logic                rob_full,
  output logic                rob_empty,
  output logic                retire_valid,
  output logic [XLEN-1:0]     retire_pc,
  output logic                cb_flush,
  output logic [XLEN-1:0]     cb_epc,
  output exc_cause_t          cb_cause
);

  // per-entry control bits
  logic [CB_DEPTH-1:0] valid;
  logic [CB_DEPTH-1:0] done;
  // per-entry payload
  logic [XLEN-1:0]     entry_pc    [CB_DEPTH];
  exc_cause_t          entry_cause [CB_DEPTH];

  logic [CB_IDX_W-1:0] head;
  logic [CB_IDX_W-1:0] tail;
  logic [CB_IDX_W:0]   count;

  logic alloc;
  logic wb_hit;
  logic head_done;

  assign rob_full  = (count == (CB_IDX_W+1)'(CB_DEPTH));
  assign rob_empty = (count == '0);

  // the hazard unit already holds dispatch on full, guard anyway
  assign alloc  = dispatch_ok && !rob_full;
  // ignore writebacks that target an entry dropped by a flush
  assign wb_hit = wb_valid && valid[wb_cb_idx];

  assign dispatch_cb_idx = tail;

  // head is finished, either retires cleanly or traps
  assign head_done    = valid[head] && done[head];
  assign retire_valid = head_done && (entry_cause[head] == EXC_NONE);
  assign cb_flush     = head_done && (entry_cause[head] != EXC_NONE);
  assign retire_pc    = entry_pc[head];
  assign cb_epc       = entry_pc[head];
  assign cb_cause     = entry_cause[head];

  // control state: pointers, count, valid and done
  always_ff @(posedge CLK) begin
    if (rst) begin
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (cb_flush) begin
      // trap at the head drops everything in flight
      // a dispatch in this cycle is flushed by the front end too
      valid <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (wb_hit) begin
        done[wb_cb_idx] <= 1'b1;
      end
      if (retire_valid) begin
        valid[head] <= 1'b0;
        done[head]  <= 1'b0;
        head        <= head + 1'b1;
      end
      if (alloc) begin
        valid[tail] <= 1'b1;
        done[tail]  <= 1'b0;
        tail        <= tail + 1'b1;
      end
      // at most one in and one out per cycle
      count <= count + (CB_IDX_W+1)'(alloc) - (CB_IDX_W+1)'(retire_valid);
    end
  end

  // payload writes, qualified by the control above
  always_ff @(posedge CLK) begin
    if (alloc && !cb_flush) begin
      entry_pc[tail]    <= pc_de;
      entry_cause[tail] <= EXC_NONE;
    end
    if (wb_hit) begin
      entry_cause[wb_cb_idx] <= wb_exc;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ooo_hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_hazard_unit
  import ooo_ctrl_pkg::*;
(
  // memory and unit levels
  input  logic     ihit,
  input  logic     i_mem_busy,
  input  logic     busy_du,
  input  logic     busy_ls,
  input  logic     wb_port_conflict,
  // decoding instruction
  input  logic     dispatch,
  input  fu_type_t fu_type,
  input  src_sel_t source_a_sel,
  input  src_sel_t source_b_sel,
  input  logic     wen,
  input  logic     csr,
  // execute redirect
  input  logic     mispredict,
  // scoreboard lookups
  input  logic     rs1_busy,
  input  logic     rs2_busy,
  input  logic     rd_busy,
  // completion buffer state
  input  logic     rob_full,
  input  logic     rob_empty,
  input  logic     cb_flush,
  // privilege side
  input  logic     ext_intr,
  input  logic     mie,
  input  logic     insert_priv_pc,
  // strobes and levels to the pipeline
  output logic     dispatch_ok,
  output logic     pc_en,
  output logic     stall_fetch_decode,
  output logic     npc_sel,
  output logic     fetch_decode_flush,
  output logic     decode_execute_flush,
  output logic     execute_commit_flush,
  output logic     intr,
  output logic     intr_taken
);

  logic rs1_hazard;
  logic rs2_hazard;
  logic rd_hazard;
  logic data_hazard;
  logic structural_hazard;
  logic store;
  logic store_hazard;
  logic stall_ex;
  logic update_pc_wait_ihit;

  // operand a only matters when it actually reads the register file
  always_comb begin
    case (source_a_sel)
      SRC_RS, SRC_RS_IMM: rs1_hazard = rs1_busy;
      default:            rs1_hazard = 1'b0;
    endcase
  end

  // same for operand b
  always_comb begin
    case (source_b_sel)
      SRC_RS, SRC_RS_IMM: rs2_hazard = rs2_busy;
      default:            rs2_hazard = 1'b0;
    endcase
  end

  // waw on a pending destination
  assign rd_hazard   = rd_busy & wen;
  assign data_hazard = rs1_hazard | rs2_hazard | rd_hazard;

  // busy divider or load/store unit, or a shared writeback port
  assign structural_hazard = ((fu_type == DIV_S) && busy_du) ||
                             ((fu_type == LOADSTORE_S) && busy_ls) ||
                             wb_port_conflict;

  // stores wait until everything older has retired
  assign store        = (fu_type == LOADSTORE_S) && (source_a_sel == SRC_RS_IMM);
  assign store_hazard = store && !rob_empty;

  // redirect is taken straight from execute
  assign npc_sel = mispredict;

  // hold the front end while a redirect waits for the icache
  assign update_pc_wait_ihit = (npc_sel | csr | insert_priv_pc | intr_taken) & ~ihit;
  assign stall_ex            = rob_full | update_pc_wait_ihit;

  // interrupt request, held off by a trap already at the head
  assign intr       = ext_intr & mie & ~cb_flush;
  // taken once the buffer has drained
  assign intr_taken = intr & rob_empty;

  assign stall_fetch_decode = intr | csr | stall_ex | data_hazard |
                              structural_hazard | store_hazard;

  assign pc_en       = ~(i_mem_busy | stall_fetch_decode);
  assign dispatch_ok = dispatch & ~stall_fetch_decode;

  // flushes
  assign fetch_decode_flush   = npc_sel | insert_priv_pc | csr | cb_flush;
  // only once the new fetch is back
  assign decode_execute_flush = (npc_sel | insert_priv_pc | cb_flush) & ihit;
  assign execute_commit_flush = csr | cb_flush;

endmodule

`default_nettype wire

//--- hdl/priv_csr_regs.sv
`timescale 1ns/1ns
`default_nettype none

module priv_csr_regs
  import ooo_ctrl_pkg::*;
(
  input  logic            CLK,
  input  logic            rst,
  // config port
  input  logic            cfg_wen,
  input  csr_addr_t       cfg_addr,
  input  logic [XLEN-1:0] cfg_wdata,
  // hardware capture on trap entry
  input  logic            capture,
  input  logic [XLEN-1:0] capture_pc,
  input  exc_cause_t      capture_cause,
  input  logic            mie_clear,
  output logic [XLEN-1:0] cfg_rdata,
  output logic [XLEN-1:0] mtvec,
  output logic            mie
);

  logic [XLEN-1:0] mepc;
  exc_cause_t      mcause;

  always_ff @(posedge CLK) begin
    if (rst) begin
      mtvec  <= '0;
      mie    <= 1'b0;
      mepc   <= '0;
      mcause <= EXC_NONE;
    end else begin
      // software writes, mepc and mcause are read only here
      if (cfg_wen && (cfg_addr == CSR_MTVEC)) begin
        mtvec <= cfg_wdata;
      end
      if (cfg_wen && (cfg_addr == CSR_MIE)) begin
        mie <= cfg_wdata[0];
      end
      // trap entry masks further interrupts, wins over a write
      if (mie_clear) begin
        mie <= 1'b0;
      end
      if (capture) begin
        mepc   <= capture_pc;
        mcause <= capture_cause;
      end
    end
  end

  // read mux, narrow registers are zero extended
  always_comb begin
    case (cfg_addr)
      CSR_MTVEC: cfg_rdata = mtvec;
      CSR_MIE:   cfg_rdata = {{(XLEN-1){1'b0}}, mie};
      CSR_MEPC:  cfg_rdata = mepc;
      default:   cfg_rdata = {{(XLEN-4){1'b0}}, mcause};
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/priv_exception_unit.sv
`timescale 1ns/1ns
`default_nettype none

module priv_exception_unit
  import ooo_ctrl_pkg::*;
(
  input  logic            CLK,
  input  logic            rst,
  // trap at the head of the completion buffer
  input  logic            cb_flush,
  input  logic [XLEN-1:0] cb_epc,
  input  exc_cause_t      cb_cause,
  // interrupt accepted by the hazard unit
  input  logic            intr_taken,
  input  logic [XLEN-1:0] pc_de,
  // trap vector
  input  logic [XLEN-1:0] mtvec,
  // capture strobes to the machine registers
  output logic            capture,
  output logic [XLEN-1:0] capture_pc,
  output exc_cause_t      capture_cause,
  output logic            mie_clear,
  // redirect to the handler
  output logic            insert_priv_pc,
  output logic [XLEN-1:0] priv_pc
);

  logic trap;

  // either source enters the handler
  assign trap = cb_flush | intr_taken;

  // a synchronous exception has precedence over the interrupt
  // the hazard unit already masks intr during cb_flush
  always_comb begin
    if (cb_flush) begin
      capture_pc    = cb_epc;
      capture_cause = cb_cause;
    end else begin
      // interrupt resumes at the instruction held in decode
      capture_pc    = pc_de;
      capture_cause = INTR_EXT;
    end
  end

  assign capture   = trap;
  assign mie_clear = trap;

  // one-cycle redirect pulse in the cycle after trap entry
  // mie is cleared at the same edge, so no retrigger
  always_ff @(posedge CLK) begin
    if (rst) begin
      insert_priv_pc <= 1'b0;
    end else begin
      insert_priv_pc <= trap;
    end
  end

  // handler entry is the trap vector, direct mode only
  assign priv_pc = mtvec;

endmodule

`default_nettype wire

//--- hdl/ooo_control_top.sv
`timescale 1ns/1ns
`default_nettype none

module ooo_control_top
  import ooo_ctrl_pkg::*;
(
  input  logic                 CLK,
  input  logic                 rst,
  // decode
  input  logic                 dispatch,
  input  fu_type_t             fu_type,
  input  src_sel_t             source_a_sel,
  input  src_sel_t             source_b_sel,
  input  logic [REG_IDX_W-1:0] rs1,
  input  logic [REG_IDX_W-1:0] rs2,
  input  logic [REG_IDX_W-1:0] rd,
  input  logic                 wen,
  input  logic [XLEN-1:0]      pc_de,
  input  logic                 csr,
  // execute, resolved_pc goes to the fetch mux in the datapath
  input  logic                 mispredict,
  input  logic [XLEN-1:0]      resolved_pc,
  // memory and unit levels
  input  logic                 ihit,
  input  logic                 i_mem_busy,
  input  logic                 busy_du,
  input  logic                 busy_ls,
  input  logic                 wb_port_conflict,
  // writeback
  input  logic                 wb_valid,
  input  logic [CB_IDX_W-1:0]  wb_cb_idx,
  input  logic [REG_IDX_W-1:0] wb_rd,
  input  logic                 wb_wen,
  input  exc_cause_t           wb_exc,
  input  logic                 ext_intr,
  // config port
  input  logic                 cfg_wen,
  input  csr_addr_t            cfg_addr,
  input  logic [XLEN-1:0]      cfg_wdata,
  // pipeline control
  output logic                 pc_en,
  output logic                 stall_fetch_decode,
  output logic                 fetch_decode_flush,
  output logic                 decode_execute_flush,
  output logic                 execute_commit_flush,
  output logic                 npc_sel,
  output logic                 insert_priv_pc,
  output logic [XLEN-1:0]      priv_pc,
  // commit side
  output logic [CB_IDX_W-1:0]  dispatch_cb_idx,
  output logic                 retire_valid,
  output logic [XLEN-1:0]      retire_pc,
  output logic                 rob_full,
  output logic                 rob_empty,
  output logic [XLEN-1:0]      cfg_rdata
);

  logic            dispatch_ok;
  logic            rs1_busy;
  logic            rs2_busy;
  logic            rd_busy;
  logic            cb_flush;
  logic [XLEN-1:0] cb_epc;
  exc_cause_t      cb_cause;
  logic            intr_taken;
  logic [XLEN-1:0] mtvec;
  logic            mie;
  logic            capture;
  logic [XLEN-1:0] capture_pc;
  exc_cause_t      capture_cause;
  logic            mie_clear;

  register_scoreboard u_scoreboard (
    .CLK        (CLK),
    .rst        (rst),
    .dispatch_ok(dispatch_ok),
    .wen        (wen),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .wb_wen     (wb_wen),
    .wb_rd      (wb_rd),
    .rs1_busy   (rs1_busy),
    .rs2_busy   (rs2_busy),
    .rd_busy    (rd_busy)
  );

  completion_buffer u_cb (
    .CLK            (CLK),
    .rst            (rst),
    .dispatch_ok    (dispatch_ok),
    .pc_de          (pc_de),
    .wb_valid       (wb_valid),
    .wb_cb_idx      (wb_cb_idx),
    .wb_exc         (wb_exc),
    .dispatch_cb_idx(dispatch_cb_idx),
    .rob_full       (rob_full),
    .rob_empty      (rob_empty),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .cb_flush       (cb_flush),
    .cb_epc         (cb_epc),
    .cb_cause       (cb_cause)
  );

  // intr itself stays inside the hazard unit
  ooo_hazard_unit u_hazard (
    .ihit                (ihit),
    .i_mem_busy          (i_mem_busy),
    .busy_du             (busy_du),
    .busy_ls             (busy_ls),
    .wb_port_conflict    (wb_port_conflict),
    .dispatch            (dispatch),
    .fu_type             (fu_type),
    .source_a_sel        (source_a_sel),
    .source_b_sel        (source_b_sel),
    .wen                 (wen),
    .csr                 (csr),
    .mispredict          (mispredict),
    .rs1_busy            (rs1_busy),
    .rs2_busy            (rs2_busy),
    .rd_busy             (rd_busy),
    .rob_full            (rob_full),
    .rob_empty           (rob_empty),
    .cb_flush            (cb_flush),
    .ext_intr            (ext_intr),
    .mie                 (mie),
    .insert_priv_pc      (insert_priv_pc),
    .dispatch_ok         (dispatch_ok),
    .pc_en               (pc_en),
    .stall_fetch_decode  (stall_fetch_decode),
    .npc_sel             (npc_sel),
    .fetch_decode_flush  (fetch_decode_flush),
    .decode_execute_flush(decode_execute_flush),
    .execute_commit_flush(execute_commit_flush),
    .intr                (),
    .intr_taken          (intr_taken)
  );

  priv_csr_regs u_csr (
    .CLK          (CLK),
    .rst          (rst),
    .cfg_wen      (cfg_wen),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .capture      (capture),
    .capture_pc   (capture_pc),
    .capture_cause(capture_cause),
    .mie_clear    (mie_clear),
    .cfg_rdata    (cfg_rdata),
    .mtvec        (mtvec),
    .mie          (mie)
  );

  priv_exception_unit u_exc (
    .CLK           (CLK),
    .rst           (rst),
    .cb_flush      (cb_flush),
    .cb_epc        (cb_epc),
    .cb_cause      (cb_cause),
    .intr_taken    (intr_taken),
    .pc_de         (pc_de),
    .mtvec         (mtvec),
    .capture       (capture),
    .capture_pc    (capture_pc),
    .capture_cause (capture_cause),
    .mie_clear     (mie_clear),
    .insert_priv_pc(insert_priv_pc),
    .priv_pc       (priv_pc)
  );

endmodule

`default_nettype wire

//--- tests/tb_ooo_control.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ooo_control
  import ooo_ctrl_pkg::*;
;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_CYCLES   = 4000;
  // stimulus bias changes every this many cycles
  localparam int MODE_LEN     = 250;

  logic                 CLK;
  logic                 rst;
  logic                 dispatch;
  fu_type_t             fu_type;
  src_sel_t             source_a_sel;
  src_sel_t             source_b_sel;
  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic [REG_IDX_W-1:0] rd;
  logic                 wen;
  logic [XLEN-1:0]      pc_de;
  logic                 csr;
  logic                 mispredict;
  logic [XLEN-1:0]      resolved_pc;
  logic                 ihit;
  logic                 i_mem_busy;
  logic                 busy_du;
  logic                 busy_ls;
  logic                 wb_port_conflict;
  logic                 wb_valid;
  logic [CB_IDX_W-1:0]  wb_cb_idx;
  logic [REG_IDX_W-1:0] wb_rd;
  logic                 wb_wen;
  exc_cause_t           wb_exc;
  logic                 ext_intr;
  logic                 cfg_wen;
  csr_addr_t            cfg_addr;
  logic [XLEN-1:0]      cfg_wdata;
  logic                 pc_en;
  logic                 stall_fetch_decode;
  logic                 fetch_decode_flush;
  logic                 decode_execute_flush;
  logic                 execute_commit_flush;
  logic                 npc_sel;
  logic                 insert_priv_pc;
  logic [XLEN-1:0]      priv_pc;
  logic [CB_IDX_W-1:0]  dispatch_cb_idx;
  logic                 retire_valid;
  logic [XLEN-1:0]      retire_pc;
  logic                 rob_full;
  logic                 rob_empty;
  logic [XLEN-1:0]      cfg_rdata;

  // scoreboard model
  logic [NUM_REGS-1:0] m_busy;
  // buffer model entries with the oldest at the front
  int                  q_idx[$];
  logic [XLEN-1:0]     q_pc[$];
  exc_cause_t          q_cause[$];
  bit                  q_done[$];
  int                  m_tail;
  // machine register and redirect pulse model
  logic [XLEN-1:0]     m_mtvec;
  logic                m_mie;
  logic [XLEN-1:0]     m_mepc;
  exc_cause_t          m_mcause;
  logic                m_insert;

  // expected combinational values for the current cycle
  logic            e_stall;
  logic            e_pc_en;
  logic            e_dispatch_ok;
  logic            e_full;
  logic            e_empty;
  logic            e_retire;
  logic            e_cb_flush;
  logic            e_intr_taken;
  logic            e_fd_flush;
  logic            e_de_flush;
  logic            e_ec_flush;
  logic [XLEN-1:0] e_rdata;

  int n_retired;
  int n_traps;
  int n_intr;
  int n_full;

  ooo_control_top DUT (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic bit chance(input int percent);
    return ($urandom_range(0, 99) < percent);
  endfunction

  // SRC_RS and SRC_RS_IMM read the register file
  function automatic bit reads_reg(input src_sel_t sel);
    return (sel == SRC_RS) || (sel == SRC_RS_IMM);
  endfunction

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s actual %h expected %h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic reset_model();
    m_busy = '0;
    q_idx.delete();
    q_pc.delete();
    q_cause.delete();
    q_done.delete();
    m_tail   = 0;
    m_mtvec  = '0;
    m_mie    = 1'b0;
    m_mepc   = '0;
    m_mcause = EXC_NONE;
    m_insert = 1'b0;
  endtask

  task automatic idle_inputs();
    dispatch         = 1'b0;
    fu_type          = ALU_S;
    source_a_sel     = SRC_IMM;
    source_b_sel     = SRC_IMM;
    rs1              = '0;
    rs2              = '0;
    rd               = '0;
    wen              = 1'b0;
    pc_de            = '0;
    csr              = 1'b0;
    mispredict       = 1'b0;
    resolved_pc      = '0;
    ihit             = 1'b1;
    i_mem_busy       = 1'b0;
    busy_du          = 1'b0;
    busy_ls          = 1'b0;
    wb_port_conflict = 1'b0;
    wb_valid         = 1'b0;
    wb_cb_idx        = '0;
    wb_rd            = '0;
    wb_wen           = 1'b0;
    wb_exc           = EXC_NONE;
    ext_intr         = 1'b0;
    cfg_wen          = 1'b0;
    cfg_addr         = CSR_MTVEC;
    cfg_wdata        = '0;
  endtask

  // mode 0 is mixed traffic, 1 fills the buffer, 2 drains it and 3 raises interrupts
  task automatic drive_inputs(input int mode);
    int open_pos[$];
    int busy_regs[$];
    int wb_pct;
    int pick;
    for (int p = 0; p < q_idx.size(); p++) begin
      if (!q_done[p]) begin
        open_pos.push_back(p);
      end
    end
    for (int r = 1; r < NUM_REGS; r++) begin
      if (m_busy[r]) begin
        busy_regs.push_back(r);
      end
    end
    // decoding instruction over a small register range so hazards are frequent
    dispatch     = chance(mode == 2 ? 25 : 70);
    fu_type      = fu_type_t'(2'($urandom_range(0, 3)));
    source_a_sel = src_sel_t'(2'($urandom_range(0, 3)));
    source_b_sel = src_sel_t'(2'($urandom_range(0, 3)));
    rs1          = REG_IDX_W'($urandom_range(0, 7));
    rs2          = REG_IDX_W'($urandom_range(0, 7));
    rd           = REG_IDX_W'($urandom_range(0, 7));
    wen          = chance(70);
    pc_de        = $urandom() & 32'hffff_fffc;
    csr          = chance(3);
    mispredict   = chance(5);
    resolved_pc  = $urandom() & 32'hffff_fffc;
    // unit and memory levels
    ihit             = chance(80);
    i_mem_busy       = chance(10);
    busy_du          = chance(25);
    busy_ls          = chance(25);
    wb_port_conflict = chance(5);
    ext_intr         = chance(mode == 3 ? 30 : 3);
    // buffer completion to a random outstanding entry
    case (mode)
      1:       wb_pct = 0;
      2:       wb_pct = 70;
      default: wb_pct = 35;
    endcase
    if ((open_pos.size() > 0) && chance(wb_pct)) begin
      pick      = open_pos[$urandom_range(0, open_pos.size() - 1)];
      wb_valid  = 1'b1;
      wb_cb_idx = CB_IDX_W'(q_idx[pick]);
      wb_exc    = chance(6) ? exc_cause_t'(4'($urandom_range(1, 6))) : EXC_NONE;
    end else begin
      wb_valid  = 1'b0;
      wb_cb_idx = CB_IDX_W'($urandom_range(0, CB_DEPTH - 1));
      wb_exc    = EXC_NONE;
    end
    // register writeback to a pending destination
    if ((busy_regs.size() > 0) && chance(40)) begin
      wb_wen = 1'b1;
      wb_rd  = REG_IDX_W'(busy_regs[$urandom_range(0, busy_regs.size() - 1)]);
    end else begin
      wb_wen = 1'b0;
      wb_rd  = REG_IDX_W'($urandom_range(0, 7));
    end
    // config port address also selects the readback
    cfg_wen  = chance(mode == 3 ? 10 : 5);
    cfg_addr = csr_addr_t'(2'($urandom_range(0, 3)));
    if (cfg_addr == CSR_MIE) begin
      cfg_wdata = {31'b0, chance(80)};
    end else begin
      cfg_wdata = $urandom();
    end
  endtask

  task automatic compute_expected();
    logic data_h;
    logic struct_h;
    logic store_h;
    logic head_done;
    logic intr;
    logic wait_ihit;
    data_h = (m_busy[rs1] && reads_reg(source_a_sel)) ||
             (m_busy[rs2] && reads_reg(source_b_sel)) ||
             (m_busy[rd] && wen);
    struct_h = ((fu_type == DIV_S) && busy_du) ||
               ((fu_type == LOADSTORE_S) && busy_ls) ||
               wb_port_conflict;
    e_empty = (q_idx.size() == 0);
    e_full  = (q_idx.size() == CB_DEPTH);
    // a store waits for an empty buffer
    store_h    = (fu_type == LOADSTORE_S) && (source_a_sel == SRC_RS_IMM) && !e_empty;
    head_done  = !e_empty && q_done[0];
    e_retire   = head_done && (q_cause[0] == EXC_NONE);
    e_cb_flush = head_done && (q_cause[0] != EXC_NONE);
    intr         = ext_intr && m_mie && !e_cb_flush;
    e_intr_taken = intr && e_empty;
    wait_ihit    = (mispredict || csr || m_insert || e_intr_taken) && !ihit;
    e_stall = intr || csr || e_full || wait_ihit || data_h || struct_h || store_h;
    e_pc_en       = !(i_mem_busy || e_stall);
    e_dispatch_ok = dispatch && !e_stall;
    e_fd_flush = mispredict || m_insert || csr || e_cb_flush;
    e_de_flush = (mispredict || m_insert || e_cb_flush) && ihit;
    e_ec_flush = csr || e_cb_flush;
    case (cfg_addr)
      CSR_MTVEC: e_rdata = m_mtvec;
      CSR_MIE:   e_rdata = {31'b0, m_mie};
      CSR_MEPC:  e_rdata = m_mepc;
      default:   e_rdata = 32'(m_mcause);
    endcase
  endtask

  task automatic check_outputs();
    compute_expected();
    check_equal("stall_fetch_decode", stall_fetch_decode, e_stall);
    check_equal("pc_en", pc_en, e_pc_en);
    check_equal("npc_sel", npc_sel, mispredict);
    check_equal("fetch_decode_flush", fetch_decode_flush, e_fd_flush);
    check_equal("decode_execute_flush", decode_execute_flush, e_de_flush);
    check_equal("execute_commit_flush", execute_commit_flush, e_ec_flush);
    check_equal("insert_priv_pc", insert_priv_pc, m_insert);
    check_equal("priv_pc", priv_pc, m_mtvec);
    check_equal("dispatch_cb_idx", dispatch_cb_idx, m_tail);
    check_equal("rob_full", rob_full, e_full);
    check_equal("rob_empty", rob_empty, e_empty);
    check_equal("retire_valid", retire_valid, e_retire);
    // head pc is only meaningful with an entry present
    if (!e_empty) begin
      check_equal("retire_pc", retire_pc, q_pc[0]);
    end
    check_equal("cfg_rdata", cfg_rdata, e_rdata);
  endtask

  // apply this cycle's inputs to the model as the edge does to the DUT
  task automatic advance_model();
    logic trap;
    trap = e_cb_flush || e_intr_taken;
    n_retired += e_retire;
    n_traps   += e_cb_flush;
    n_intr    += e_intr_taken;
    n_full    += e_full;
    // machine registers capture the head before it is dropped
    if (cfg_wen && (cfg_addr == CSR_MTVEC)) begin
      m_mtvec = cfg_wdata;
    end
    if (cfg_wen && (cfg_addr == CSR_MIE)) begin
      m_mie = cfg_wdata[0];
    end
    if (trap) begin
      m_mie    = 1'b0;
      m_mepc   = e_cb_flush ? q_pc[0] : pc_de;
      m_mcause = e_cb_flush ? q_cause[0] : INTR_EXT;
    end
    m_insert = trap;
    // scoreboard update where a same-edge set beats the clear
    if (wb_wen && (wb_rd != '0)) begin
      m_busy[wb_rd] = 1'b0;
    end
    if (e_dispatch_ok && wen && (rd != '0)) begin
      m_busy[rd] = 1'b1;
    end
    // completion buffer
    if (e_cb_flush) begin
      q_idx.delete();
      q_pc.delete();
      q_cause.delete();
      q_done.delete();
      m_tail = 0;
    end else begin
      if (wb_valid) begin
        for (int p = 0; p < q_idx.size(); p++) begin
          if (q_idx[p] == wb_cb_idx) begin
            q_done[p]  = 1'b1;
            q_cause[p] = wb_exc;
          end
        end
      end
      if (e_retire) begin
        void'(q_idx.pop_front());
        void'(q_pc.pop_front());
        void'(q_cause.pop_front());
        void'(q_done.pop_front());
      end
      if (e_dispatch_ok) begin
        q_idx.push_back(m_tail);
        q_pc.push_back(pc_de);
        q_cause.push_back(EXC_NONE);
        q_done.push_back(1'b0);
        m_tail = (m_tail + 1) % CB_DEPTH;
      end
    end
  endtask

  // watchdog sized from the reset and test lengths plus a margin
  initial begin
    #((RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD);
    $display("timeout: the test loop did not finish in the expected time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin
    n_retired = 0;
    n_traps   = 0;
    n_intr    = 0;
    n_full    = 0;
    void'($urandom(32'h66722e7f));
    CLK = 1'b0;
    rst = 1'b1;
    idle_inputs();
    reset_model();
    repeat (RESET_CYCLES) @(posedge CLK);
    #5;
    rst = 1'b0;
    // state right after reset with idle inputs
    check_outputs();
    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge CLK);
      #5;
      drive_inputs((cyc / MODE_LEN) % 4);
      // sample just before the next edge
      #85;
      check_outputs();
      advance_model();
    end
    $display("retired %0d, traps %0d, interrupts %0d, full cycles %0d",
             n_retired, n_traps, n_intr, n_full);
    // each behavior group has to show up at least once
    if ((n_retired == 0) || (n_traps == 0) || (n_intr == 0) || (n_full == 0)) begin
      $display("the stimulus never reached a retire, a trap, an interrupt or a full buffer");
      $display("Finished with errors");
      $fatal(1, "behavior not exercised");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
hdl/ooo_ctrl_pkg.sv
hdl/register_scoreboard.sv
hdl/completion_buffer.sv
hdl/ooo_hazard_unit.sv
hdl/priv_csr_regs.sv
hdl/priv_exception_unit.sv
hdl/ooo_control_top.sv
tests/tb_ooo_control.sv
